/* logic/mem_test_consts.svh */
`ifndef MEM_TEST_CONSTS_SVH
`define MEM_TEST_CONSTS_SVH

// striping across this many chips
`define NUM_S 4

// async sram geometry
`define SRAM_ADDR_WIDTH 18
`define SRAM_DATA_WIDTH 16

// test size per run, kept small for simulation
`define NUM_BURSTS 4
`define NUM_BEATS 8

// cycles of internal reset after the external one is released
`define RST_CYCLES 15

// done counter bit on LED1
`define LED_CNT_BIT 3

`endif

/* logic/mem_test_pkg.sv */
`include "mem_test_consts.svh"

package mem_test_pkg;

  // one data word on a chip bus
  typedef logic [`SRAM_DATA_WIDTH-1:0] sram_word_t;

  // address inside a single chip
  typedef logic [`SRAM_ADDR_WIDTH-1:0] sram_addr_t;

  // linear word index, chip select bits sit at the bottom
  typedef logic [`SRAM_ADDR_WIDTH+$clog2(`NUM_S)-1:0] word_idx_t;

  // run number, mixed into the data pattern
  typedef logic [7:0] run_cnt_t;

  // tester sequencing
  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    WDRAIN,
    READ,
    RDRAIN,
    DONE
  } tester_state_t;

endpackage

/* logic/reset_init.sv */
`timescale 1ns/100ps

`include "mem_test_consts.svh"

module reset_init (
  input  logic CLK,
  input  logic rst_n,
  output logic core_rst_n
);

  localparam int CNT_W = $clog2(`RST_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`RST_CYCLES);

  logic [CNT_W-1:0] cnt;

  // count up after release, let the core go once the count is reached
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      cnt        <= '0;
      core_rst_n <= 1'b0;
    end else if (cnt != CNT_LAST) begin
      cnt <= cnt + 1'b1;
    end else begin
      core_rst_n <= 1'b1;
    end
  end

endmodule

/* logic/sram_if_ctrl.sv */
`timescale 1ns/100ps

`include "mem_test_consts.svh"

module sram_if_ctrl (
  input  logic                        CLK,
  input  logic                        rst_n,
  input  logic                        op,
  input  logic                        op_we,
  input  mem_test_pkg::sram_addr_t    op_addr,
  input  mem_test_pkg::sram_word_t    op_data,
  output logic                        busy,
  output logic                        rd_valid,
  output mem_test_pkg::sram_word_t    rd_data,
  output mem_test_pkg::sram_addr_t    sram_addr,
  output logic                        sram_we_n,
  output logic                        sram_oe_n,
  inout  wire [`SRAM_DATA_WIDTH-1:0]  sram_data
);

  import mem_test_pkg::*;

  logic       accept;
  logic       phase1;
  logic       phase2;
  logic       we_r;
  logic       drive_en;
  sram_word_t wdata_r;

  assign accept = op && !busy;
  assign busy   = phase1 || phase2;

  // bus is ours only for writes, held one cycle past we_n rising
  assign sram_data = drive_en ? wdata_r : 'z;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      phase1    <= 1'b0;
      phase2    <= 1'b0;
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
      drive_en  <= 1'b0;
      rd_valid  <= 1'b0;
    end else begin
      phase1    <= accept;
      phase2    <= phase1;
      // we_n low in the second cycle only
      sram_we_n <= !(phase1 && we_r);
      // oe_n low across both cycles of a read
      sram_oe_n <= !((accept && !op_we) || (phase1 && !we_r));
      drive_en  <= (accept && op_we) || (busy && we_r);
      rd_valid  <= phase2 && !we_r;
    end
  end

  // op capture, address and data stay put until the next accept
  always_ff @(posedge CLK) begin
    if (accept) begin
      we_r      <= op_we;
      sram_addr <= op_addr;
      wdata_r   <= op_data;
    end
    // sample at the end of the second read cycle
    if (phase2 && !we_r) begin
      rd_data <= sram_data;
    end
  end

  // the chip must never see both strobes at once
  assert property (@(posedge CLK) disable iff (!rst_n)
    !(!sram_we_n && !sram_oe_n));

  // router is expected to hold back while this chip is busy
  assert property (@(posedge CLK) disable iff (!rst_n)
    busy |-> !op);

endmodule

/* logic/stripe_router.sv */
`timescale 1ns/100ps

`include "mem_test_consts.svh"

module stripe_router (
  input  logic                      CLK,
  input  logic                      rst_n,
  input  logic                      req,
  input  logic                      req_we,
  input  mem_test_pkg::word_idx_t   req_idx,
  input  mem_test_pkg::sram_word_t  req_data,
  output logic                      stall,
  output logic                      rd_valid,
  output mem_test_pkg::sram_word_t  rd_data,
  output logic [`NUM_S-1:0]         chip_op,
  output logic [`NUM_S-1:0]         chip_we,
  output mem_test_pkg::sram_addr_t  chip_addr [`NUM_S],
  output mem_test_pkg::sram_word_t  chip_wdata [`NUM_S],
  input  logic [`NUM_S-1:0]         chip_busy,
  input  logic [`NUM_S-1:0]         chip_rd_valid,
  input  mem_test_pkg::sram_word_t  chip_rd_data [`NUM_S]
);

  import mem_test_pkg::*;

  localparam int SEL_W = $clog2(`NUM_S);

  logic [SEL_W-1:0] sel;
  sram_addr_t       addr;

  // chip is idx mod NUM_S, chip address is idx div NUM_S
  assign sel   = req_idx[SEL_W-1:0];
  assign addr  = req_idx[SEL_W +: `SRAM_ADDR_WIDTH];
  assign stall = chip_busy[sel];

  // fan out, only the target chip gets the strobe
  always_comb begin
    for (int i = 0; i < `NUM_S; i++) begin
      chip_op[i]    = req && (sel == SEL_W'(i)) && !chip_busy[i];
      chip_we[i]    = req_we;
      chip_addr[i]  = addr;
      chip_wdata[i] = req_data;
    end
  end

  // fixed latency per chip keeps returns in issue order
  always_comb begin
    rd_valid = 1'b0;
    rd_data  = '0;
    for (int i = 0; i < `NUM_S; i++) begin
      rd_valid = rd_valid | chip_rd_valid[i];
      rd_data  = rd_data | ({`SRAM_DATA_WIDTH{chip_rd_valid[i]}} & chip_rd_data[i]);
    end
  end

  // one issue per cycle means returns never collide
  assert property (@(posedge CLK) disable iff (!rst_n)
    $onehot0(chip_rd_valid));

endmodule

/* logic/pattern_tester.sv */
`timescale 1ns/100ps

`include "mem_test_consts.svh"

module pattern_tester (
  input  logic                      CLK,
  input  logic                      rst_n,
  output logic                      req,
  output logic                      req_we,
  output mem_test_pkg::word_idx_t   req_idx,
  output mem_test_pkg::sram_word_t  req_data,
  input  logic                      stall,
  input  logic                      chip_idle,
  input  logic                      rd_valid,
  input  mem_test_pkg::sram_word_t  rd_data,
  output logic                      test_done,
  output logic                      test_pass
);

  import mem_test_pkg::*;

  localparam word_idx_t LAST_IDX = word_idx_t'(`NUM_BURSTS * `NUM_BEATS - 1);

  tester_state_t state;
  word_idx_t     issue_idx;
  word_idx_t     cmp_idx;
  run_cnt_t      run;
  logic          err;
  logic          accepted;
  logic          mismatch;
  logic          last_cmp;
  sram_word_t    expected;

  // word w of run r: low bits of w with the run number in the upper byte
  function automatic sram_word_t pattern(word_idx_t w, run_cnt_t r);
    return w[`SRAM_DATA_WIDTH-1:0] ^ (sram_word_t'(r) << 8);
  endfunction

  assign req       = (state == WRITE) || (state == READ);
  assign req_we    = (state == WRITE);
  assign req_idx   = issue_idx;
  assign req_data  = pattern(issue_idx, run);
  assign accepted  = req && !stall;
  assign test_done = (state == DONE);

  // read data comes back in order, so a running index is enough
  assign expected = pattern(cmp_idx, run);
  assign mismatch = rd_valid && (rd_data != expected);
  assign last_cmp = rd_valid && (cmp_idx == LAST_IDX);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state     <= IDLE;
      issue_idx <= '0;
      cmp_idx   <= '0;
      run       <= '0;
      err       <= 1'b0;
      test_pass <= 1'b1;
    end else begin
      if (rd_valid) begin
        cmp_idx <= cmp_idx + 1'b1;
      end
      err <= err || mismatch;

      case (state)
        IDLE: begin
          state <= WRITE;
        end
        // both passes walk the same index range
        WRITE, READ: begin
          if (accepted) begin
            if (issue_idx == LAST_IDX) begin
              issue_idx <= '0;
              state     <= (state == WRITE) ? WDRAIN : RDRAIN;
            end else begin
              issue_idx <= issue_idx + 1'b1;
            end
          end
        end
        // let the last writes land before reading back
        WDRAIN: begin
          if (chip_idle) begin
            state <= READ;
          end
        end
        RDRAIN: begin
          if (last_cmp) begin
            test_pass <= !(err || mismatch);
            state     <= DONE;
          end
        end
        DONE: begin
          run     <= run + 1'b1;
          err     <= 1'b0;
          cmp_idx <= '0;
          state   <= WRITE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // read returns only show up while a read pass is in progress
  assert property (@(posedge CLK) disable iff (!rst_n)
    rd_valid |-> (state == READ || state == RDRAIN));

endmodule

/* logic/striped_sram_test_top.sv */
`timescale 1ns/100ps

`include "mem_test_consts.svh"

module striped_sram_test_top (
  input  logic                                   CLK,
  input  logic                                   rst_n,
  output logic                                   LED1,
  output logic                                   test_done,
  output logic                                   test_pass,
  output logic [`NUM_S-1:0]                      sram_oe_n,
  output logic [`NUM_S-1:0]                      sram_we_n,
  output logic [`NUM_S-1:0]                      sram_ub_n,
  output logic [`NUM_S-1:0]                      sram_lb_n,
  output logic [`NUM_S-1:0][`SRAM_ADDR_WIDTH-1:0] sram_addr,
  inout  wire  [`NUM_S-1:0][`SRAM_DATA_WIDTH-1:0] sram_data
);

  import mem_test_pkg::*;

  logic              core_rst_n;
  logic              req;
  logic              req_we;
  word_idx_t         req_idx;
  sram_word_t        req_data;
  logic              stall;
  logic              rd_valid;
  sram_word_t        rd_data;
  logic              chip_idle;
  logic [`NUM_S-1:0] chip_op;
  logic [`NUM_S-1:0] chip_we;
  sram_addr_t        chip_addr [`NUM_S];
  sram_word_t        chip_wdata [`NUM_S];
  logic [`NUM_S-1:0] chip_busy;
  logic [`NUM_S-1:0] chip_rd_valid;
  sram_word_t        chip_rd_data [`NUM_S];
  logic [7:0]        done_cnt;

  reset_init i_reset_init (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .core_rst_n(core_rst_n)
  );

  pattern_tester i_tester (
    .CLK      (CLK),
    .rst_n    (core_rst_n),
    .req      (req),
    .req_we   (req_we),
    .req_idx  (req_idx),
    .req_data (req_data),
    .stall    (stall),
    .chip_idle(chip_idle),
    .rd_valid (rd_valid),
    .rd_data  (rd_data),
    .test_done(test_done),
    .test_pass(test_pass)
  );

  stripe_router i_router (
    .CLK          (CLK),
    .rst_n        (core_rst_n),
    .req          (req),
    .req_we       (req_we),
    .req_idx      (req_idx),
    .req_data     (req_data),
    .stall        (stall),
    .rd_valid     (rd_valid),
    .rd_data      (rd_data),
    .chip_op      (chip_op),
    .chip_we      (chip_we),
    .chip_addr    (chip_addr),
    .chip_wdata   (chip_wdata),
    .chip_busy    (chip_busy),
    .chip_rd_valid(chip_rd_valid),
    .chip_rd_data (chip_rd_data)
  );

  // one controller per chip, all running in parallel
  for (genvar i = 0; i < `NUM_S; i++) begin : g_chip
    sram_if_ctrl i_ctrl (
      .CLK      (CLK),
      .rst_n    (core_rst_n),
      .op       (chip_op[i]),
      .op_we    (chip_we[i]),
      .op_addr  (chip_addr[i]),
      .op_data  (chip_wdata[i]),
      .busy     (chip_busy[i]),
      .rd_valid (chip_rd_valid[i]),
      .rd_data  (chip_rd_data[i]),
      .sram_addr(sram_addr[i]),
      .sram_we_n(sram_we_n[i]),
      .sram_oe_n(sram_oe_n[i]),
      .sram_data(sram_data[i])
    );
  end

  assign chip_idle = ~|chip_busy;

  // full words only
  assign sram_ub_n = '0;
  assign sram_lb_n = '0;

  // completed runs, one bit shown as a heartbeat
  always_ff @(posedge CLK) begin
    if (!core_rst_n) begin
      done_cnt <= '0;
    end else if (test_done) begin
      done_cnt <= done_cnt + 1'b1;
    end
  end

  assign LED1 = done_cnt[`LED_CNT_BIT];

endmodule

/* tests/sram_model.sv */
`timescale 1ns/100ps

`include "mem_test_consts.svh"

module sram_model (
  input  logic [`SRAM_ADDR_WIDTH-1:0] addr,
  input  logic                        we_n,
  input  logic                        oe_n,
  input  logic                        ub_n,
  input  logic                        lb_n,
  inout  wire  [`SRAM_DATA_WIDTH-1:0] data,
  input  logic                        stuck_en,
  input  logic [3:0]                  stuck_bit,
  output int                          wr_count
);

  import mem_test_pkg::*;

  localparam int DEPTH = 1 << `SRAM_ADDR_WIDTH;

  sram_word_t mem [DEPTH];
  sram_word_t rd_word;
  logic       armed;

  // power-up contents, every address bit shows up in the word
  initial begin
    for (int a = 0; a < DEPTH; a++) begin
      mem[a] = sram_word_t'(a) ^ {14'h0, 2'(a >> 16)} ^ 16'ha5c3;
    end
    wr_count = 0;
    armed    = 1'b0;
  end

  // a write needs we_n low first, so the reset edge is not a write
  always @(negedge we_n) begin
    armed = 1'b1;
  end

  // the chip latches address and data on the rising edge of we_n
  always @(posedge we_n) begin
    if (armed) begin
      if (!lb_n) begin
        mem[addr][7:0] = data[7:0];
      end
      if (!ub_n) begin
        mem[addr][15:8] = data[15:8];
      end
      wr_count = wr_count + 1;
      armed    = 1'b0;
    end
  end

  // stuck-at-1 fault only on the read path, the array stays clean
  assign rd_word = mem[addr] | (stuck_en ? (sram_word_t'(1) << stuck_bit) : '0);
  assign data    = (!oe_n && we_n) ? rd_word : 'z;

endmodule

/* tests/tb_striped_sram_test.sv */
`timescale 1ns/100ps

`include "mem_test_consts.svh"

module tb_striped_sram_test;

  import mem_test_pkg::*;

  localparam int WORDS       = `NUM_BURSTS * `NUM_BEATS;
  localparam int WR_PER_CHIP = WORDS / `NUM_S;
  localparam int TIMEOUT     = 5000;

  logic                                    CLK;
  logic                                    rst_n;
  logic                                    LED1;
  logic                                    test_done;
  logic                                    test_pass;
  logic [`NUM_S-1:0]                       sram_oe_n;
  logic [`NUM_S-1:0]                       sram_we_n;
  logic [`NUM_S-1:0]                       sram_ub_n;
  logic [`NUM_S-1:0]                       sram_lb_n;
  logic [`NUM_S-1:0][`SRAM_ADDR_WIDTH-1:0] sram_addr;
  wire  [`NUM_S-1:0][`SRAM_DATA_WIDTH-1:0] sram_data;
  logic [`NUM_S-1:0]                       stuck_en;
  logic [3:0]                              stuck_bit;
  int                                      wr_count [`NUM_S];
  int                                      done_seen;
  integer                                  seed;

  striped_sram_test_top i_dut (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .LED1     (LED1),
    .test_done(test_done),
    .test_pass(test_pass),
    .sram_oe_n(sram_oe_n),
    .sram_we_n(sram_we_n),
    .sram_ub_n(sram_ub_n),
    .sram_lb_n(sram_lb_n),
    .sram_addr(sram_addr),
    .sram_data(sram_data)
  );

  for (genvar i = 0; i < `NUM_S; i++) begin : g_mem
    sram_model i_sram (
      .addr     (sram_addr[i]),
      .we_n     (sram_we_n[i]),
      .oe_n     (sram_oe_n[i]),
      .ub_n     (sram_ub_n[i]),
      .lb_n     (sram_lb_n[i]),
      .data     (sram_data[i]),
      .stuck_en (stuck_en[i]),
      .stuck_bit(stuck_bit),
      .wr_count (wr_count[i])
    );
  end

  initial CLK = 1'b0;
  always #10 CLK = ~CLK;

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_eq(string name, logic [31:0] got, logic [31:0] exp);
    assert (got == exp) else begin
      $display("error: time %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // run number xored into the upper byte of the word index
  function automatic sram_word_t expected_word(int w, int r);
    return sram_word_t'(w) ^ (sram_word_t'(r & 8'hff) << 8);
  endfunction

  function automatic sram_word_t peek_word(int chip, int addr);
    sram_word_t value;
    case (chip)
      0: value = g_mem[0].i_sram.mem[addr];
      1: value = g_mem[1].i_sram.mem[addr];
      2: value = g_mem[2].i_sram.mem[addr];
      default: value = g_mem[3].i_sram.mem[addr];
    endcase
    return value;
  endfunction

  // a stuck-at-1 bit is only seen if some word on that chip has it at 0
  function automatic bit stuck_visible(int chip, int pos, int run);
    sram_word_t word;
    for (int w = chip; w < WORDS; w += `NUM_S) begin
      word = expected_word(w, run);
      if (!word[pos]) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic wait_for_done();
    int cycles;
    cycles = 0;
    @(negedge CLK);
    while (!test_done && cycles < TIMEOUT) begin
      @(negedge CLK);
      cycles++;
    end
    assert (test_done) else begin
      $display("timeout: test_done did not arrive within %0d cycles", TIMEOUT);
      abort_run();
    end
    done_seen++;
  endtask

  task automatic check_memory(int run);
    for (int w = 0; w < WORDS; w++) begin
      check_eq($sformatf("g_mem[%0d].i_sram.mem[%0d]", w % `NUM_S, w / `NUM_S),
               peek_word(w % `NUM_S, w / `NUM_S), expected_word(w, run));
    end
  endtask

  task automatic check_write_counts(int runs);
    for (int c = 0; c < `NUM_S; c++) begin
      check_eq($sformatf("wr_count[%0d]", c), wr_count[c], runs * WR_PER_CHIP);
    end
  endtask

  task automatic reset_test();
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    check_eq("sram_oe_n", sram_oe_n, {`NUM_S{1'b1}});
    check_eq("sram_we_n", sram_we_n, {`NUM_S{1'b1}});
    check_eq("sram_ub_n", sram_ub_n, 0);
    check_eq("sram_lb_n", sram_lb_n, 0);
    check_eq("test_done", test_done, 0);
    check_eq("test_pass", test_pass, 1);
    @(posedge CLK);
    rst_n <= 1'b1;
    // core held in reset while the init counter runs
    repeat (`RST_CYCLES) begin
      @(negedge CLK);
      check_eq("test_done", test_done, 0);
      check_eq("sram_oe_n", sram_oe_n, {`NUM_S{1'b1}});
      check_eq("sram_we_n", sram_we_n, {`NUM_S{1'b1}});
    end
  endtask

  task automatic clean_run_test();
    wait_for_done();
    check_eq("test_pass", test_pass, 1);
    check_write_counts(1);
    check_memory(0);
  endtask

  task automatic repeated_runs_test();
    while (done_seen < 8) begin
      wait_for_done();
      check_eq("test_pass", test_pass, 1);
    end
    check_memory(done_seen - 1);
    check_write_counts(done_seen);
    // done counter moves on the edge after the pulse
    @(negedge CLK);
    check_eq("LED1", LED1, done_seen[3]);
  endtask

  task automatic fault_test();
    int chip;
    int pos;
    int tries;
    int run;
    run   = done_seen;
    tries = 0;
    chip  = $unsigned($random(seed)) % `NUM_S;
    pos   = $unsigned($random(seed)) % `SRAM_DATA_WIDTH;
    while (!stuck_visible(chip, pos, run) && tries < 32) begin
      chip = $unsigned($random(seed)) % `NUM_S;
      pos  = $unsigned($random(seed)) % `SRAM_DATA_WIDTH;
      tries++;
    end
    assert (stuck_visible(chip, pos, run)) else begin
      $display("no observable stuck bit found in 32 random picks");
      abort_run();
    end
    @(posedge CLK);
    stuck_en[chip] <= 1'b1;
    stuck_bit      <= pos[3:0];
    wait_for_done();
    check_eq("test_pass", test_pass, 0);
    @(posedge CLK);
    stuck_en <= '0;
    wait_for_done();
    check_eq("test_pass", test_pass, 1);
    check_memory(done_seen - 1);
  endtask

  initial begin
    seed      = 5;
    rst_n     = 1'b0;
    stuck_en  = '0;
    stuck_bit = '0;
    done_seen = 0;
    reset_test();
    clean_run_test();
    repeated_runs_test();
    fault_test();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* files.f */
+incdir+logic
logic/mem_test_pkg.sv
logic/reset_init.sv
logic/sram_if_ctrl.sv
logic/stripe_router.sv
logic/pattern_tester.sv
logic/striped_sram_test_top.sv
tests/sram_model.sv
tests/tb_striped_sram_test.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and judge the result from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module tb_striped_sram_test -o tb_sim > sim.log 2>&1 &&
  ./obj_dir/tb_sim >> sim.log 2>&1 ||
  echo "build or simulation returned an error status" >> sim.log
grep -q "Simulation completed successfully" sim.log && echo "PASS" ||
  { echo "FAIL, see sim.log"; exit 1; }
